//--- alu_reg_md_iq.f
+incdir+testbench
rtl/alu_reg_md_iq_pkg.sv
rtl/pq_lsb.sv
rtl/iq_dispatch_alloc.sv
rtl/iq_entry_array.sv
rtl/iq_issue_select.sv
rtl/alu_reg_md_iq.sv
testbench/alu_reg_md_iq_tb.sv

//--- Makefile
SIM := obj_dir/Valu_reg_md_iq_tb

.PHONY: all run clean

all: run

$(SIM): alu_reg_md_iq.f $(wildcard rtl/*.sv testbench/*.sv testbench/*.svh)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f alu_reg_md_iq.f --top-module alu_reg_md_iq_tb

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- testbench/alu_reg_md_iq_tb_checks.svh
`ifndef ALU_REG_MD_IQ_TB_CHECKS_SVH
`define ALU_REG_MD_IQ_TB_CHECKS_SVH

    // ------------------------------------------------------------------------
    // compare tasks, one per kind of DUT result

    // single valid bit of a pipeline
    task automatic check_valid(input int row, input string name, input logic got,
                               input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH row %0d %s: got %h expected %h", row, name, got, exp);
        end
    endtask

    // per-way ready advertisement
    task automatic check_adv(input int row, input logic [DISPATCH_WAYS-1:0] got,
                             input logic [DISPATCH_WAYS-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH row %0d dispatch_ready_advertisement: got %h expected %h",
                     row, got, exp);
        end
    endtask

    // issue word as a whole
    task automatic check_issue_op(input int row, input string name,
                                  input alu_reg_md_iq_pkg::issue_op_t got,
                                  input alu_reg_md_iq_pkg::issue_op_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH row %0d %s: got %h expected %h", row, name, got, exp);
        end
    endtask

    // register read request
    task automatic check_prf_req(input int row, input string name,
                                 input alu_reg_md_iq_pkg::prf_req_t got,
                                 input alu_reg_md_iq_pkg::prf_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH row %0d %s: got %h expected %h", row, name, got, exp);
        end
    endtask

`endif

//--- testbench/alu_reg_md_iq_tb.sv
`timescale 1ns/10ps

module alu_reg_md_iq_tb;

    localparam int IQ_ENTRIES    = 8;
    localparam int DISPATCH_WAYS = 4;
    localparam int RESET_CYCLES  = 16;

    // one cycle of stimulus plus what the outputs must show before the next edge
    typedef struct packed {
        logic [DISPATCH_WAYS-1:0]                                           attempt;
        alu_reg_md_iq_pkg::iq_op_t [DISPATCH_WAYS-1:0]                      ops;
        logic                                                               alu_ready;
        logic                                                               md_ready;
        alu_reg_md_iq_pkg::wb_bus_t [alu_reg_md_iq_pkg::PRF_BANK_COUNT-1:0] wb;
        logic [DISPATCH_WAYS-1:0]                                           exp_adv;
        logic                                                               exp_alu_valid;
        alu_reg_md_iq_pkg::issue_op_t                                       exp_alu_op;
        alu_reg_md_iq_pkg::prf_req_t                                        exp_alu_req;
        logic                                                               exp_md_valid;
        alu_reg_md_iq_pkg::issue_op_t                                       exp_md_op;
        alu_reg_md_iq_pkg::prf_req_t                                        exp_md_req;
    } row_t;

    logic CLK = 1'b0;
    logic nRST;

    logic [DISPATCH_WAYS-1:0]                                           dispatch_attempt_by_way;
    alu_reg_md_iq_pkg::iq_op_t [DISPATCH_WAYS-1:0]                      dispatch_op_by_way;
    logic [DISPATCH_WAYS-1:0]                                           dispatch_ready_advertisement;
    logic                                                               alu_reg_pipeline_ready;
    logic                                                               mul_div_pipeline_ready;
    alu_reg_md_iq_pkg::wb_bus_t [alu_reg_md_iq_pkg::PRF_BANK_COUNT-1:0] wb_bus;
    logic                                                               issue_alu_reg_valid;
    alu_reg_md_iq_pkg::issue_op_t                                       issue_alu_reg_op;
    alu_reg_md_iq_pkg::prf_req_t                                        prf_alu_reg_req;
    logic                                                               issue_mul_div_valid;
    alu_reg_md_iq_pkg::issue_op_t                                       issue_mul_div_op;
    alu_reg_md_iq_pkg::prf_req_t                                        prf_mul_div_req;

    int   error_count   = 0;
    int   check_count   = 0;
    int   cycle_count   = 0;
    int   timeout_limit = 0;
    row_t rows[$];

    `include "alu_reg_md_iq_tb_checks.svh"

    alu_reg_md_iq #(
        .IQ_ENTRIES(IQ_ENTRIES),
        .DISPATCH_WAYS(DISPATCH_WAYS)
    ) alu_reg_md_iq_i (
        .CLK(CLK),
        .nRST(nRST),
        .dispatch_attempt_by_way(dispatch_attempt_by_way),
        .dispatch_op_by_way(dispatch_op_by_way),
        .dispatch_ready_advertisement(dispatch_ready_advertisement),
        .alu_reg_pipeline_ready(alu_reg_pipeline_ready),
        .mul_div_pipeline_ready(mul_div_pipeline_ready),
        .wb_bus(wb_bus),
        .issue_alu_reg_valid(issue_alu_reg_valid),
        .issue_alu_reg_op(issue_alu_reg_op),
        .prf_alu_reg_req(prf_alu_reg_req),
        .issue_mul_div_valid(issue_mul_div_valid),
        .issue_mul_div_op(issue_mul_div_op),
        .prf_mul_div_req(prf_mul_div_req)
    );

    // 10 ns period
    always #5 CLK = ~CLK;

    // run limit counted in rising edges
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: table still running after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // row building

    // is_md picks the mul-div kind over alu reg-reg
    function automatic alu_reg_md_iq_pkg::iq_op_t make_op(
        input logic is_md, input logic [3:0] op, input logic [6:0] a_pr, input logic a_rdy,
        input logic [6:0] b_pr, input logic b_rdy, input logic [6:0] dest, input logic [6:0] rob);
        alu_reg_md_iq_pkg::iq_op_t o;
        o               = '0;
        o.valid_alu_reg = ~is_md;
        o.valid_mul_div = is_md;
        o.op            = op;
        o.A_PR.index    = a_pr;
        o.A_ready       = a_rdy;
        o.B_PR.index    = b_pr;
        o.B_ready       = b_rdy;
        o.dest_PR       = dest;
        o.ROB_index     = rob;
        return o;
    endfunction

    // bank field is just the low PR bits
    function automatic alu_reg_md_iq_pkg::issue_op_t expect_issue(
        input alu_reg_md_iq_pkg::iq_op_t o, input logic a_fwd, input logic b_fwd);
        alu_reg_md_iq_pkg::issue_op_t w;
        w.op        = o.op;
        w.A_forward = a_fwd;
        w.A_bank    = o.A_PR.index[alu_reg_md_iq_pkg::LOG_PRF_BANK_COUNT-1:0];
        w.B_forward = b_fwd;
        w.B_bank    = o.B_PR.index[alu_reg_md_iq_pkg::LOG_PRF_BANK_COUNT-1:0];
        w.dest_PR   = o.dest_PR;
        w.ROB_index = o.ROB_index;
        return w;
    endfunction

    // forwarded operand needs no read
    function automatic alu_reg_md_iq_pkg::prf_req_t expect_req(
        input alu_reg_md_iq_pkg::iq_op_t o, input logic a_fwd, input logic b_fwd);
        alu_reg_md_iq_pkg::prf_req_t q;
        q.A_valid = ~a_fwd;
        q.A_PR    = o.A_PR.index;
        q.B_valid = ~b_fwd;
        q.B_PR    = o.B_PR.index;
        return q;
    endfunction

    // way k open while entry N-WAYS+k is past the filled count
    function automatic logic [DISPATCH_WAYS-1:0] adv_for_count(input int filled);
        logic [DISPATCH_WAYS-1:0] a;
        for (int k = 0; k < DISPATCH_WAYS; k++) begin
            a[k] = (IQ_ENTRIES - DISPATCH_WAYS + k) >= filled;
        end
        return a;
    endfunction

    // idle cycle with both pipes ready and the bus quiet
    function automatic row_t idle_row();
        row_t r;
        r           = '0;
        r.alu_ready = 1'b1;
        r.md_ready  = 1'b1;
        r.exp_adv   = '1;
        return r;
    endfunction

    function automatic row_t expect_alu(input row_t r, input alu_reg_md_iq_pkg::iq_op_t o,
                                        input logic a_fwd, input logic b_fwd);
        r.exp_alu_valid = 1'b1;
        r.exp_alu_op    = expect_issue(o, a_fwd, b_fwd);
        r.exp_alu_req   = expect_req(o, a_fwd, b_fwd);
        return r;
    endfunction

    function automatic row_t expect_md(input row_t r, input alu_reg_md_iq_pkg::iq_op_t o,
                                       input logic a_fwd, input logic b_fwd);
        r.exp_md_valid = 1'b1;
        r.exp_md_op    = expect_issue(o, a_fwd, b_fwd);
        r.exp_md_req   = expect_req(o, a_fwd, b_fwd);
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus table

    task automatic build_table();
        alu_reg_md_iq_pkg::iq_op_t x1;
        alu_reg_md_iq_pkg::iq_op_t p0;
        alu_reg_md_iq_pkg::iq_op_t p1;
        alu_reg_md_iq_pkg::iq_op_t p2;
        alu_reg_md_iq_pkg::iq_op_t p3;
        alu_reg_md_iq_pkg::iq_op_t w1;
        alu_reg_md_iq_pkg::iq_op_t w2;
        alu_reg_md_iq_pkg::iq_op_t ab;
        alu_reg_md_iq_pkg::iq_op_t md [8];
        row_t                      r;
        x1 = make_op(1'b0, 4'h3, 7'h11, 1'b1, 7'h22, 1'b1, 7'h33, 7'h01);
        p0 = make_op(1'b0, 4'h1, 7'h04, 1'b1, 7'h05, 1'b1, 7'h30, 7'h02);
        p1 = make_op(1'b0, 4'h2, 7'h06, 1'b1, 7'h07, 1'b1, 7'h31, 7'h03);
        p2 = make_op(1'b1, 4'h9, 7'h0A, 1'b1, 7'h0B, 1'b1, 7'h32, 7'h04);
        p3 = make_op(1'b0, 4'h4, 7'h0C, 1'b1, 7'h0F, 1'b1, 7'h34, 7'h05);
        // A waits on PR 0x2d in bank 1 with upper 0x0b
        w1 = make_op(1'b0, 4'h5, 7'h2D, 1'b0, 7'h40, 1'b1, 7'h41, 7'h10);
        // A waits on PR 0x56 in bank 2 with upper 0x15
        w2 = make_op(1'b0, 4'h6, 7'h56, 1'b0, 7'h07, 1'b1, 7'h5A, 7'h11);
        ab = make_op(1'b0, 4'h7, 7'h1C, 1'b1, 7'h1D, 1'b1, 7'h3F, 7'h28);
        for (int k = 0; k < 8; k++) begin
            md[k] = make_op(1'b1, 4'(8 + k), 7'(96 + k), 1'b1, 7'(104 + k), 1'b1,
                            7'(112 + k), 7'(32 + k));
        end

        // reset state
        rows.push_back(idle_row());

        // one alu op in and out
        r = idle_row();
        r.attempt = 4'b0001;
        r.ops[0] = x1;
        rows.push_back(r);
        rows.push_back(expect_alu(idle_row(), x1, 1'b0, 1'b0));
        rows.push_back(idle_row());

        // four ways at once then entries 0 and 2 go together
        r = idle_row();
        r.attempt = 4'b1111;
        r.ops = {p3, p2, p1, p0};
        rows.push_back(r);
        rows.push_back(expect_md(expect_alu(idle_row(), p0, 1'b0, 1'b0), p2, 1'b0, 1'b0));
        // p1 compressed into entry 0
        rows.push_back(expect_alu(idle_row(), p1, 1'b0, 1'b0));
        rows.push_back(expect_alu(idle_row(), p3, 1'b0, 1'b0));

        // wakeup forwarded same cycle
        r = idle_row();
        r.attempt = 4'b0001;
        r.ops[0] = w1;
        rows.push_back(r);
        // bus busy on the wrong bank and with the wrong upper bits
        r = idle_row();
        r.wb[0].valid = 1'b1;
        r.wb[0].upper = 5'h0B;
        r.wb[1].valid = 1'b1;
        r.wb[1].upper = 5'h0C;
        rows.push_back(r);
        r = expect_alu(idle_row(), w1, 1'b1, 1'b0);
        r.wb[1].valid = 1'b1;
        r.wb[1].upper = 5'h0B;
        rows.push_back(r);

        // ready bit sticks when the wakeup hits a stall
        r = idle_row();
        r.attempt = 4'b0001;
        r.ops[0] = w2;
        rows.push_back(r);
        r = idle_row();
        r.alu_ready = 1'b0;
        r.wb[2].valid = 1'b1;
        r.wb[2].upper = 5'h15;
        rows.push_back(r);
        rows.push_back(expect_alu(idle_row(), w2, 1'b0, 1'b0));

        // mul-div held back while the alu op leaves from the middle
        r = idle_row();
        r.md_ready = 1'b0;
        r.attempt = 4'b1111;
        r.ops = {md[2], ab, md[1], md[0]};
        rows.push_back(r);
        r = expect_alu(idle_row(), ab, 1'b0, 1'b0);
        r.md_ready = 1'b0;
        r.attempt = 4'b0011;
        r.ops[0] = md[3];
        r.ops[1] = md[4];
        rows.push_back(r);
        // five held so only the upper three ways are offered
        r = idle_row();
        r.md_ready = 1'b0;
        r.exp_adv = adv_for_count(5);
        r.attempt = 4'b1110;
        r.ops[1] = md[5];
        r.ops[2] = md[6];
        r.ops[3] = md[7];
        rows.push_back(r);
        r = idle_row();
        r.md_ready = 1'b0;
        r.exp_adv = adv_for_count(8);
        rows.push_back(r);

        // drain oldest first as slots reopen from the top
        for (int k = 0; k < 8; k++) begin
            r = expect_md(idle_row(), md[k], 1'b0, 1'b0);
            r.exp_adv = adv_for_count(8 - k);
            rows.push_back(r);
        end
        rows.push_back(idle_row());

        timeout_limit = rows.size() + RESET_CYCLES + 20;
    endtask

    // ------------------------------------------------------------------------
    // apply and check

    task automatic drive_row(input row_t r);
        dispatch_attempt_by_way = r.attempt;
        dispatch_op_by_way      = r.ops;
        alu_reg_pipeline_ready  = r.alu_ready;
        mul_div_pipeline_ready  = r.md_ready;
        wb_bus                  = r.wb;
    endtask

    // issue word only meaningful with valid high
    task automatic check_row(input int idx, input row_t r);
        int errors_before;
        errors_before = error_count;
        check_adv(idx, dispatch_ready_advertisement, r.exp_adv);
        check_valid(idx, "issue_alu_reg_valid", issue_alu_reg_valid, r.exp_alu_valid);
        if (r.exp_alu_valid) begin
            check_issue_op(idx, "issue_alu_reg_op", issue_alu_reg_op, r.exp_alu_op);
            check_prf_req(idx, "prf_alu_reg_req", prf_alu_reg_req, r.exp_alu_req);
        end
        check_valid(idx, "issue_mul_div_valid", issue_mul_div_valid, r.exp_md_valid);
        if (r.exp_md_valid) begin
            check_issue_op(idx, "issue_mul_div_op", issue_mul_div_op, r.exp_md_op);
            check_prf_req(idx, "prf_mul_div_req", prf_mul_div_req, r.exp_md_req);
        end
        if (error_count == errors_before) begin
            $display("row %0d ok", idx);
        end
        else begin
            $display("row %0d failed with %0d errors", idx, error_count - errors_before);
        end
    endtask

    initial begin
        build_table();
        nRST = 1'b0;
        drive_row(idle_row());
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // drive 1 ns after the edge and sample 1 ns before the next
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge CLK);
            #1;
            drive_row(rows[i]);
            #8;
            check_row(i, rows[i]);
        end

        $display("summary: %0d rows, %0d checks, %0d errors",
                 rows.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/alu_reg_md_iq.sv
`timescale 1ns/10ps

module alu_reg_md_iq #(
    parameter int IQ_ENTRIES    = 8,
    parameter int DISPATCH_WAYS = 4
) (
    input  logic CLK,
    input  logic nRST,

    // dispatch
    input  logic [DISPATCH_WAYS-1:0]                         dispatch_attempt_by_way,
    input  alu_reg_md_iq_pkg::iq_op_t [DISPATCH_WAYS-1:0]    dispatch_op_by_way,
    output logic [DISPATCH_WAYS-1:0]                         dispatch_ready_advertisement,

    // pipeline feedback
    input  logic                                             alu_reg_pipeline_ready,
    input  logic                                             mul_div_pipeline_ready,

    // writeback, one bus per bank
    input  alu_reg_md_iq_pkg::wb_bus_t [alu_reg_md_iq_pkg::PRF_BANK_COUNT-1:0] wb_bus,

    // alu reg-reg issue
    output logic                                             issue_alu_reg_valid,
    output alu_reg_md_iq_pkg::issue_op_t                     issue_alu_reg_op,
    output alu_reg_md_iq_pkg::prf_req_t                      prf_alu_reg_req,

    // mul-div issue
    output logic                                             issue_mul_div_valid,
    output alu_reg_md_iq_pkg::issue_op_t                     issue_mul_div_op,
    output alu_reg_md_iq_pkg::prf_req_t                      prf_mul_div_req
);

    alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0] entry;
    logic [IQ_ENTRIES-1:0]                      entry_valid;
    logic [IQ_ENTRIES-1:0]                      A_forward_by_entry;
    logic [IQ_ENTRIES-1:0]                      B_forward_by_entry;

    alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0] dispatch_op_by_entry;
    logic [IQ_ENTRIES-1:0]                      dispatch_valid_by_entry;

    logic [IQ_ENTRIES-1:0]                      alu_reg_kind_by_entry;
    logic [IQ_ENTRIES-1:0]                      mul_div_kind_by_entry;
    logic [IQ_ENTRIES-1:0]                      alu_reg_issue_mask;
    logic [IQ_ENTRIES-1:0]                      mul_div_issue_mask;

    // split kind bits out per pipeline
    for (genvar i = 0; i < IQ_ENTRIES; i++) begin : g_kind
        assign alu_reg_kind_by_entry[i] = entry[i].valid_alu_reg;
        assign mul_div_kind_by_entry[i] = entry[i].valid_mul_div;
    end

    iq_entry_array #(
        .IQ_ENTRIES(IQ_ENTRIES)
    ) entry_array_i (
        .CLK(CLK),
        .nRST(nRST),
        .wb_bus(wb_bus),
        .dispatch_valid_by_entry(dispatch_valid_by_entry),
        .dispatch_op_by_entry(dispatch_op_by_entry),
        .alu_reg_issue_mask(alu_reg_issue_mask),
        .mul_div_issue_mask(mul_div_issue_mask),
        .entry(entry),
        .entry_valid(entry_valid),
        .A_forward_by_entry(A_forward_by_entry),
        .B_forward_by_entry(B_forward_by_entry)
    );

    iq_dispatch_alloc #(
        .IQ_ENTRIES(IQ_ENTRIES),
        .DISPATCH_WAYS(DISPATCH_WAYS)
    ) dispatch_alloc_i (
        .entry_valid(entry_valid),
        .dispatch_attempt_by_way(dispatch_attempt_by_way),
        .dispatch_op_by_way(dispatch_op_by_way),
        .dispatch_ready_advertisement(dispatch_ready_advertisement),
        .dispatch_valid_by_entry(dispatch_valid_by_entry),
        .dispatch_op_by_entry(dispatch_op_by_entry)
    );

    // ------------------------------------------------------------------------
    // one selector per pipeline

    iq_issue_select #(
        .IQ_ENTRIES(IQ_ENTRIES)
    ) alu_reg_select_i (
        .entry(entry),
        .A_forward_by_entry(A_forward_by_entry),
        .B_forward_by_entry(B_forward_by_entry),
        .kind_valid_by_entry(alu_reg_kind_by_entry),
        .pipeline_ready(alu_reg_pipeline_ready),
        .issue_valid(issue_alu_reg_valid),
        .issue_op(issue_alu_reg_op),
        .prf_req(prf_alu_reg_req),
        .issue_mask(alu_reg_issue_mask)
    );

    iq_issue_select #(
        .IQ_ENTRIES(IQ_ENTRIES)
    ) mul_div_select_i (
        .entry(entry),
        .A_forward_by_entry(A_forward_by_entry),
        .B_forward_by_entry(B_forward_by_entry),
        .kind_valid_by_entry(mul_div_kind_by_entry),
        .pipeline_ready(mul_div_pipeline_ready),
        .issue_valid(issue_mul_div_valid),
        .issue_op(issue_mul_div_op),
        .prf_req(prf_mul_div_req),
        .issue_mask(mul_div_issue_mask)
    );

endmodule

//--- rtl/iq_issue_select.sv
`timescale 1ns/10ps

module iq_issue_select #(
    parameter int IQ_ENTRIES = 8
) (
    input  alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0] entry,
    input  logic [IQ_ENTRIES-1:0]                      A_forward_by_entry,
    input  logic [IQ_ENTRIES-1:0]                      B_forward_by_entry,
    input  logic [IQ_ENTRIES-1:0]                      kind_valid_by_entry,
    input  logic                                       pipeline_ready,
    output logic                                       issue_valid,
    output alu_reg_md_iq_pkg::issue_op_t               issue_op,
    output alu_reg_md_iq_pkg::prf_req_t                prf_req,
    output logic [IQ_ENTRIES-1:0]                      issue_mask
);

    // both operands there, held or forwarded this cycle
    logic [IQ_ENTRIES-1:0]         operands_ok;
    logic [IQ_ENTRIES-1:0]         ready_by_entry;
    logic [$clog2(IQ_ENTRIES)-1:0] pick_index;

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            operands_ok[i] = (entry[i].A_ready | A_forward_by_entry[i])
                & (entry[i].B_ready | B_forward_by_entry[i]);
        end
    end

    // stalled pipeline sees no candidates
    assign ready_by_entry = {IQ_ENTRIES{pipeline_ready}} & kind_valid_by_entry & operands_ok;

    // oldest first, entry 0 is oldest
    pq_lsb #(
        .WIDTH(IQ_ENTRIES)
    ) issue_pq (
        .req_vec(ready_by_entry),
        .ack_one_hot(),
        .ack_mask(issue_mask),
        .ack_index(pick_index)
    );

    assign issue_valid = |ready_by_entry;

    // ------------------------------------------------------------------------
    // output mux

    always_comb begin
        issue_op.op        = entry[pick_index].op;
        issue_op.A_forward = A_forward_by_entry[pick_index];
        issue_op.A_bank    = entry[pick_index].A_PR.split.bank;
        issue_op.B_forward = B_forward_by_entry[pick_index];
        issue_op.B_bank    = entry[pick_index].B_PR.split.bank;
        issue_op.dest_PR   = entry[pick_index].dest_PR;
        issue_op.ROB_index = entry[pick_index].ROB_index;

        // forwarded operands skip the register read
        prf_req.A_valid = ~A_forward_by_entry[pick_index];
        prf_req.A_PR    = entry[pick_index].A_PR.index;
        prf_req.B_valid = ~B_forward_by_entry[pick_index];
        prf_req.B_PR    = entry[pick_index].B_PR.index;
    end

endmodule

//--- rtl/iq_entry_array.sv
`timescale 1ns/10ps

module iq_entry_array #(
    parameter int IQ_ENTRIES = 8
) (
    input  logic CLK,
    input  logic nRST,

    input  alu_reg_md_iq_pkg::wb_bus_t [alu_reg_md_iq_pkg::PRF_BANK_COUNT-1:0] wb_bus,

    input  logic [IQ_ENTRIES-1:0]                      dispatch_valid_by_entry,
    input  alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0] dispatch_op_by_entry,

    input  logic [IQ_ENTRIES-1:0]                      alu_reg_issue_mask,
    input  logic [IQ_ENTRIES-1:0]                      mul_div_issue_mask,

    output alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0] entry,
    output logic [IQ_ENTRIES-1:0]                      entry_valid,
    output logic [IQ_ENTRIES-1:0]                      A_forward_by_entry,
    output logic [IQ_ENTRIES-1:0]                      B_forward_by_entry
);

    // issued at or below each index plus a spare top bit
    logic [IQ_ENTRIES:0] alu_reg_le;
    logic [IQ_ENTRIES:0] mul_div_le;

    // last entry of each mask is the issued one
    logic [IQ_ENTRIES-1:0] alu_reg_end;
    logic [IQ_ENTRIES-1:0] mul_div_end;

    alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0] next_entry;

    // ------------------------------------------------------------------------
    // wakeup

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            entry_valid[i] = entry[i].valid_alu_reg | entry[i].valid_mul_div;
            // bank bits pick the bus and upper bits must match it
            A_forward_by_entry[i] = wb_bus[entry[i].A_PR.split.bank].valid
                & (wb_bus[entry[i].A_PR.split.bank].upper == entry[i].A_PR.split.upper);
            B_forward_by_entry[i] = wb_bus[entry[i].B_PR.split.bank].valid
                & (wb_bus[entry[i].B_PR.split.bank].upper == entry[i].B_PR.split.upper);
        end
    end

    // ------------------------------------------------------------------------
    // compression

    // flip the masks so a bit means the issued entry sits at or below it
    assign alu_reg_le = {1'b0, {IQ_ENTRIES{alu_reg_issue_mask[0]}} & ~(alu_reg_issue_mask >> 1)};
    assign mul_div_le = {1'b0, {IQ_ENTRIES{mul_div_issue_mask[0]}} & ~(mul_div_issue_mask >> 1)};

    assign alu_reg_end = alu_reg_issue_mask & ~(alu_reg_issue_mask >> 1);
    assign mul_div_end = mul_div_issue_mask & ~(mul_div_issue_mask >> 1);

    always_comb begin
        int src;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            // two gone when one sits at or below i and the other at or below i+1
            if ((alu_reg_le[i] & mul_div_le[i+1]) | (mul_div_le[i] & alu_reg_le[i+1])) begin
                src = i + 2;
            end
            else if (alu_reg_le[i] | mul_div_le[i]) begin
                src = i + 1;
            end
            else begin
                src = i;
            end

            // nothing left above the top
            if (src >= IQ_ENTRIES) begin
                next_entry[i] = entry[i];
                next_entry[i].valid_alu_reg = 1'b0;
                next_entry[i].valid_mul_div = 1'b0;
            end
            // live entry moves and a wakeup turns sticky
            else if (entry_valid[src]) begin
                next_entry[i] = entry[src];
                next_entry[i].A_ready = entry[src].A_ready | A_forward_by_entry[src];
                next_entry[i].B_ready = entry[src].B_ready | B_forward_by_entry[src];
            end
            // empty source takes the dispatch slot
            else begin
                next_entry[i] = dispatch_op_by_entry[src];
                next_entry[i].valid_alu_reg = dispatch_op_by_entry[src].valid_alu_reg
                    & dispatch_valid_by_entry[src];
                next_entry[i].valid_mul_div = dispatch_op_by_entry[src].valid_mul_div
                    & dispatch_valid_by_entry[src];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            entry <= '0;
        end
        else begin
            entry <= next_entry;
        end
    end

    // one entry can't feed both pipelines
    a_issue_distinct: assert property (@(posedge CLK) disable iff (~nRST)
        (alu_reg_end & mul_div_end) == '0)
        else $error("iq_entry_array: both pipelines issued the same entry");

    // live entries stay packed at the bottom with no holes
    a_entries_packed: assert property (@(posedge CLK) disable iff (~nRST)
        ((entry_valid + IQ_ENTRIES'(1)) & entry_valid) == '0)
        else $error("iq_entry_array: hole in the entry array %b", entry_valid);

endmodule

//--- rtl/iq_dispatch_alloc.sv
`timescale 1ns/10ps

module iq_dispatch_alloc #(
    parameter int IQ_ENTRIES    = 8,
    parameter int DISPATCH_WAYS = 4
) (
    input  logic [IQ_ENTRIES-1:0]                            entry_valid,
    input  logic [DISPATCH_WAYS-1:0]                         dispatch_attempt_by_way,
    input  alu_reg_md_iq_pkg::iq_op_t [DISPATCH_WAYS-1:0]    dispatch_op_by_way,
    output logic [DISPATCH_WAYS-1:0]                         dispatch_ready_advertisement,
    output logic [IQ_ENTRIES-1:0]                            dispatch_valid_by_entry,
    output alu_reg_md_iq_pkg::iq_op_t [IQ_ENTRIES-1:0]       dispatch_op_by_entry
);

    // ------------------------------------------------------------------------
    // cascaded open-entry picks

    // entries still open as seen by each way
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0] open_by_way;
    // open entries gated by the way's attempt
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0] req_by_way;
    // chosen entry per way, one-hot or zero
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0] pick_by_way;

    for (genvar w = 0; w < DISPATCH_WAYS; w++) begin : g_way

        // way 0 sees every empty entry
        if (w == 0) begin : g_first
            assign open_by_way[w] = ~entry_valid;
        end
        // later ways lose what earlier ways took
        else begin : g_next
            assign open_by_way[w] = open_by_way[w-1] & ~pick_by_way[w-1];
        end

        assign req_by_way[w] = open_by_way[w] & {IQ_ENTRIES{dispatch_attempt_by_way[w]}};

        pq_lsb #(
            .WIDTH(IQ_ENTRIES)
        ) dispatch_pq (
            .req_vec(req_by_way[w]),
            .ack_one_hot(pick_by_way[w]),
            .ack_mask(),
            .ack_index()
        );

        // way k looks at top entry N-WAYS+k
        assign dispatch_ready_advertisement[w] = ~entry_valid[IQ_ENTRIES-DISPATCH_WAYS+w];
    end

    // ------------------------------------------------------------------------
    // way to entry crossbar

    always_comb begin
        logic [DISPATCH_WAYS-1:0] hit;
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            hit = '0;
            dispatch_op_by_entry[e] = '0;
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                hit[w] = pick_by_way[w][e];
                if (pick_by_way[w][e]) begin
                    dispatch_op_by_entry[e] = dispatch_op_by_way[w];
                end
            end
            dispatch_valid_by_entry[e] = |hit;
        end
    end

endmodule

//--- rtl/pq_lsb.sv
`timescale 1ns/10ps

module pq_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [WIDTH-1:0]         ack_one_hot,
    output logic [WIDTH-1:0]         ack_mask,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    localparam int IDX_W = $clog2(WIDTH);

    // isolate lowest set bit with the two's complement trick
    assign ack_one_hot = req_vec & (~req_vec + WIDTH'(1));

    // picked bit plus everything under it
    // zero when nothing is requested
    assign ack_mask = (|req_vec) ? (ack_one_hot | (ack_one_hot - WIDTH'(1))) : '0;

    // encode
    always_comb begin
        ack_index = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (ack_one_hot[i]) begin
                ack_index = IDX_W'(i);
            end
        end
    end

endmodule

//--- rtl/alu_reg_md_iq_pkg.sv
package alu_reg_md_iq_pkg;

    // ------------------------------------------------------------------------
    // widths

    // physical register index
    parameter int LOG_PR_COUNT = 7;

    // writeback bank number, taken from the low PR bits
    parameter int LOG_PRF_BANK_COUNT = 2;
    parameter int PRF_BANK_COUNT = 2 ** LOG_PRF_BANK_COUNT;

    // reorder buffer index
    parameter int LOG_ROB_ENTRIES = 7;

    // operation code
    parameter int OP_WIDTH = 4;

    // ------------------------------------------------------------------------
    // types

    // one PR word
    // whole index for the PRF read, or upper bits + bank for wakeup
    typedef union packed {
        logic [LOG_PR_COUNT-1:0] index;
        struct packed {
            logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper;
            logic [LOG_PRF_BANK_COUNT-1:0]              bank;
        } split;
    } pr_t;

    // writeback of one bank
    typedef struct packed {
        logic                                       valid;
        logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper;
    } wb_bus_t;

    // op as dispatched and as held in an entry
    // entry is empty when both kind bits are low
    typedef struct packed {
        logic                       valid_alu_reg;
        logic                       valid_mul_div;
        logic [OP_WIDTH-1:0]        op;
        pr_t                        A_PR;
        logic                       A_ready;
        pr_t                        B_PR;
        logic                       B_ready;
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } iq_op_t;

    // issue word to a pipeline
    typedef struct packed {
        logic [OP_WIDTH-1:0]           op;
        logic                          A_forward;
        logic [LOG_PRF_BANK_COUNT-1:0] A_bank;
        logic                          B_forward;
        logic [LOG_PRF_BANK_COUNT-1:0] B_bank;
        logic [LOG_PR_COUNT-1:0]       dest_PR;
        logic [LOG_ROB_ENTRIES-1:0]    ROB_index;
    } issue_op_t;

    // register read request to the PRF
    typedef struct packed {
        logic                    A_valid;
        logic [LOG_PR_COUNT-1:0] A_PR;
        logic                    B_valid;
        logic [LOG_PR_COUNT-1:0] B_PR;
    } prf_req_t;

endpackage
